// ==== verilog/xbar_pkg.sv ====
package xbar_pkg;

    // ##################################################################
    // Field widths
    // ##################################################################

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Low address bits that pick the bank.
    localparam int BANK_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BANK_W-1:0] bank_idx_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // ##################################################################
    // Default sizes
    // ##################################################################

    localparam int DEF_N_CH   = 3;
    localparam int DEF_N_BANK = 4;

    // Entries per channel buffer, a power of two.
    localparam int DEF_DEPTH  = 8;

endpackage

// ==== verilog/xbar_ptr_gen.sv ====
`timescale 1ns/1ps

module xbar_ptr_gen #(
    parameter int N_CH  = xbar_pkg::DEF_N_CH,
    parameter int DEPTH = xbar_pkg::DEF_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ch_valid  [N_CH],
    output logic                     ch_ready  [N_CH],
    input  logic                     head_done [N_CH],
    output logic                     push      [N_CH],
    output logic [$clog2(DEPTH):0]   w_ptr     [N_CH],
    output logic [$clog2(DEPTH):0]   r_ptr     [N_CH]
);

    // Index bits plus one wrap bit.
    localparam int PTR_W = $clog2(DEPTH) + 1;

    logic [PTR_W-1:0] occupancy [N_CH];

    // ##################################################################
    // Occupancy and handshake
    // ##################################################################

    always_comb begin
        for (int c = 0; c < N_CH; c++) begin
            // Wrap bit makes the difference exact up to DEPTH.
            occupancy[c] = w_ptr[c] - r_ptr[c];
            ch_ready[c]  = (occupancy[c] < PTR_W'(DEPTH));
            push[c]      = ch_valid[c] && ch_ready[c];
        end
    end

    // ##################################################################
    // Pointer registers
    // ##################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < N_CH; c++) begin
                w_ptr[c] <= '0;
                r_ptr[c] <= '0;
            end
        end else begin
            for (int c = 0; c < N_CH; c++) begin
                if (push[c]) begin
                    w_ptr[c] <= w_ptr[c] + 1'b1;
                end
                // One retired entry per cycle at most.
                if (head_done[c]) begin
                    r_ptr[c] <= r_ptr[c] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/xbar_buffer.sv ====
`timescale 1ns/1ps

module xbar_buffer #(
    parameter int N_BANK = xbar_pkg::DEF_N_BANK,
    parameter int DEPTH  = xbar_pkg::DEF_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic [$clog2(DEPTH):0]     w_ptr,
    input  logic [$clog2(DEPTH):0]     r_ptr,
    input  xbar_pkg::op_e              op,
    input  xbar_pkg::addr_t            addr,
    input  xbar_pkg::data_t            wdata,
    input  logic                       pop       [N_BANK],
    output logic                       bank_hit  [N_BANK],
    output logic [$clog2(DEPTH)-1:0]   hit_entry [N_BANK],
    output xbar_pkg::op_e              hit_op    [N_BANK],
    output xbar_pkg::addr_t            hit_addr  [N_BANK],
    output xbar_pkg::data_t            hit_wdata [N_BANK],
    output logic                       head_done
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0]    w_idx;
    logic [IDX_W-1:0]    r_idx;

    // Entry payload.
    xbar_pkg::op_e       op_q    [DEPTH];
    xbar_pkg::addr_t     addr_q  [DEPTH];
    xbar_pkg::data_t     wdata_q [DEPTH];
    xbar_pkg::bank_idx_t bank_q  [DEPTH];

    // Entry state.
    logic [DEPTH-1:0]    valid_q;
    logic [DEPTH-1:0]    popped_q;

    assign w_idx = w_ptr[IDX_W-1:0];
    assign r_idx = r_ptr[IDX_W-1:0];

    // Head slot has been sent and can be retired.
    assign head_done = valid_q[r_idx] && popped_q[r_idx];

    // ##################################################################
    // Entry storage
    // ##################################################################

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[w_idx]    <= op;
            addr_q[w_idx]  <= addr;
            wdata_q[w_idx] <= wdata;
            bank_q[w_idx]  <= addr[xbar_pkg::BANK_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            popped_q <= '0;
        end else begin
            // Retired head slot is free from the next cycle.
            if (head_done) begin
                valid_q[r_idx] <= 1'b0;
            end
            for (int b = 0; b < N_BANK; b++) begin
                if (pop[b]) begin
                    popped_q[hit_entry[b]] <= 1'b1;
                end
            end
            // Write slot never equals the head slot of a non-empty buffer.
            if (push) begin
                valid_q[w_idx]  <= 1'b1;
                popped_q[w_idx] <= 1'b0;
            end
        end
    end

    // ##################################################################
    // Oldest waiting entry per bank
    // ##################################################################

    always_comb begin
        logic [IDX_W-1:0] idx;

        idx = '0;
        for (int b = 0; b < N_BANK; b++) begin
            bank_hit[b]  = 1'b0;
            hit_entry[b] = '0;
            // Walk from the head so the first match is the oldest.
            for (int i = 0; i < DEPTH; i++) begin
                idx = r_idx + IDX_W'(i);
                if (!bank_hit[b] && valid_q[idx] && !popped_q[idx] &&
                        bank_q[idx] == xbar_pkg::bank_idx_t'(b)) begin
                    bank_hit[b]  = 1'b1;
                    hit_entry[b] = idx;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < N_BANK; b++) begin
            hit_op[b]    = op_q[hit_entry[b]];
            hit_addr[b]  = addr_q[hit_entry[b]];
            hit_wdata[b] = wdata_q[hit_entry[b]];
        end
    end

endmodule

// ==== verilog/xbar_matrix.sv ====
`timescale 1ns/1ps

module xbar_matrix #(
    parameter int N_CH   = xbar_pkg::DEF_N_CH,
    parameter int N_BANK = xbar_pkg::DEF_N_BANK,
    parameter int DEPTH  = xbar_pkg::DEF_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       bank_hit     [N_CH][N_BANK],
    input  logic [$clog2(DEPTH)-1:0]   hit_entry    [N_CH][N_BANK],
    input  xbar_pkg::op_e              hit_op       [N_CH][N_BANK],
    input  xbar_pkg::addr_t            hit_addr     [N_CH][N_BANK],
    input  xbar_pkg::data_t            hit_wdata    [N_CH][N_BANK],
    output logic                       pop          [N_CH][N_BANK],
    output logic                       bank_valid   [N_BANK],
    input  logic                       bank_ready   [N_BANK],
    output xbar_pkg::op_e              bank_op      [N_BANK],
    output xbar_pkg::addr_t            bank_addr    [N_BANK],
    output xbar_pkg::data_t            bank_wdata   [N_BANK],
    output logic [N_CH-1:0]            bank_ch_1hot [N_BANK]
);

    localparam int CH_W  = (N_CH > 1) ? $clog2(N_CH) : 1;
    localparam int IDX_W = $clog2(DEPTH);

    logic [CH_W-1:0]  rr_ptr_q     [N_BANK];
    logic             lock_q       [N_BANK];
    logic [CH_W-1:0]  lock_ch_q    [N_BANK];
    logic [IDX_W-1:0] lock_entry_q [N_BANK];
    logic [CH_W-1:0]  sel          [N_BANK];
    logic             lock_hold    [N_BANK];

    // ##################################################################
    // Grant selection
    // ##################################################################

    always_comb begin
        int cand;

        cand = 0;
        for (int b = 0; b < N_BANK; b++) begin
            // Stalled grant keeps its channel and entry.
            lock_hold[b] = lock_q[b] && bank_hit[lock_ch_q[b]][b] &&
                           hit_entry[lock_ch_q[b]][b] == lock_entry_q[b];
            sel[b]        = lock_ch_q[b];
            bank_valid[b] = lock_hold[b];
            if (!lock_hold[b]) begin
                for (int i = 0; i < N_CH; i++) begin
                    cand = int'(rr_ptr_q[b]) + i;
                    if (cand >= N_CH) begin
                        cand = cand - N_CH;
                    end
                    if (!bank_valid[b] && bank_hit[cand][b]) begin
                        bank_valid[b] = 1'b1;
                        sel[b]        = CH_W'(cand);
                    end
                end
            end
        end
    end

    // ##################################################################
    // Bank outputs and pop returns
    // ##################################################################

    always_comb begin
        for (int b = 0; b < N_BANK; b++) begin
            bank_op[b]      = hit_op[sel[b]][b];
            bank_addr[b]    = hit_addr[sel[b]][b];
            bank_wdata[b]   = hit_wdata[sel[b]][b];
            bank_ch_1hot[b] = bank_valid[b] ? (N_CH'(1) << sel[b]) : '0;
            for (int c = 0; c < N_CH; c++) begin
                pop[c][b] = bank_valid[b] && bank_ready[b] && (sel[b] == CH_W'(c));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < N_BANK; b++) begin
                rr_ptr_q[b]  <= '0;
                lock_q[b]    <= 1'b0;
                lock_ch_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < N_BANK; b++) begin
                lock_q[b] <= bank_valid[b] && !bank_ready[b];
                if (bank_valid[b] && !bank_ready[b]) begin
                    lock_ch_q[b] <= sel[b];
                end
                // Priority moves past the winner.
                if (bank_valid[b] && bank_ready[b]) begin
                    rr_ptr_q[b] <= (sel[b] == CH_W'(N_CH - 1)) ? '0 : sel[b] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < N_BANK; b++) begin
            if (bank_valid[b] && !bank_ready[b]) begin
                lock_entry_q[b] <= hit_entry[sel[b]][b];
            end
        end
    end

endmodule

// ==== verilog/xbar_core.sv ====
`timescale 1ns/1ps

module xbar_core #(
    parameter int N_CH   = xbar_pkg::DEF_N_CH,
    parameter int N_BANK = xbar_pkg::DEF_N_BANK,
    parameter int DEPTH  = xbar_pkg::DEF_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ch_valid     [N_CH],
    output logic              ch_ready     [N_CH],
    input  xbar_pkg::op_e     ch_op        [N_CH],
    input  xbar_pkg::addr_t   ch_addr      [N_CH],
    input  xbar_pkg::data_t   ch_wdata     [N_CH],
    output logic              bank_valid   [N_BANK],
    input  logic              bank_ready   [N_BANK],
    output xbar_pkg::op_e     bank_op      [N_BANK],
    output xbar_pkg::addr_t   bank_addr    [N_BANK],
    output xbar_pkg::data_t   bank_wdata   [N_BANK],
    output logic [N_CH-1:0]   bank_ch_1hot [N_BANK]
);

    logic                     push      [N_CH];
    logic                     head_done [N_CH];
    logic [$clog2(DEPTH):0]   w_ptr     [N_CH];
    logic [$clog2(DEPTH):0]   r_ptr     [N_CH];
    logic                     bank_hit  [N_CH][N_BANK];
    logic [$clog2(DEPTH)-1:0] hit_entry [N_CH][N_BANK];
    xbar_pkg::op_e            hit_op    [N_CH][N_BANK];
    xbar_pkg::addr_t          hit_addr  [N_CH][N_BANK];
    xbar_pkg::data_t          hit_wdata [N_CH][N_BANK];
    logic                     pop       [N_CH][N_BANK];

    xbar_ptr_gen #(
        .N_CH      (N_CH),
        .DEPTH     (DEPTH)
    ) u_xbar_ptr_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .ch_valid  (ch_valid),
        .ch_ready  (ch_ready),
        .head_done (head_done),
        .push      (push),
        .w_ptr     (w_ptr),
        .r_ptr     (r_ptr)
    );

    // ##################################################################
    // One request buffer per channel
    // ##################################################################

    for (genvar c = 0; c < N_CH; c++) begin : g_ch
        xbar_buffer #(
            .N_BANK    (N_BANK),
            .DEPTH     (DEPTH)
        ) u_xbar_buffer (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[c]),
            .w_ptr     (w_ptr[c]),
            .r_ptr     (r_ptr[c]),
            .op        (ch_op[c]),
            .addr      (ch_addr[c]),
            .wdata     (ch_wdata[c]),
            .pop       (pop[c]),
            .bank_hit  (bank_hit[c]),
            .hit_entry (hit_entry[c]),
            .hit_op    (hit_op[c]),
            .hit_addr  (hit_addr[c]),
            .hit_wdata (hit_wdata[c]),
            .head_done (head_done[c])
        );
    end

    xbar_matrix #(
        .N_CH         (N_CH),
        .N_BANK       (N_BANK),
        .DEPTH        (DEPTH)
    ) u_xbar_matrix (
        .clk          (clk),
        .rst_n        (rst_n),
        .bank_hit     (bank_hit),
        .hit_entry    (hit_entry),
        .hit_op       (hit_op),
        .hit_addr     (hit_addr),
        .hit_wdata    (hit_wdata),
        .pop          (pop),
        .bank_valid   (bank_valid),
        .bank_ready   (bank_ready),
        .bank_op      (bank_op),
        .bank_addr    (bank_addr),
        .bank_wdata   (bank_wdata),
        .bank_ch_1hot (bank_ch_1hot)
    );

endmodule

// ==== testbench/xbar_tb_bank.sv ====
`timescale 1ns/1ps

module xbar_tb_bank (
    input  logic clk,
    input  logic rst_n,
    input  logic hold_en,
    input  logic hold_val,
    input  logic rand_bit,
    input  logic valid,
    output logic ready,
    output int   xfer_count
);

    // A held level overrides the random pattern.
    assign ready = hold_en ? hold_val : rand_bit;

    // Count of accepted requests.
    always @(posedge clk) begin
        if (!rst_n) begin
            xfer_count <= 0;
        end else if (valid && ready) begin
            xfer_count <= xfer_count + 1;
        end
    end

endmodule

// ==== testbench/xbar_tb.sv ====
`timescale 1ns/1ps

module xbar_tb;

    localparam int N_CH      = xbar_pkg::DEF_N_CH;
    localparam int N_BANK    = xbar_pkg::DEF_N_BANK;
    localparam int DEPTH     = xbar_pkg::DEF_DEPTH;
    localparam int RAND_CYC  = 400;
    localparam int HOLD_CYC  = 2 * DEPTH;
    localparam int RR_PER_CH = 12;
    localparam int DRAIN_CYC = 4 * N_CH * DEPTH;
    localparam int OOO_CYC   = 10;
    // Budget of each test, summed, plus a margin.
    localparam int LIMIT = 10 + RAND_CYC + (2 * DEPTH + HOLD_CYC) + (8 + OOO_CYC)
                         + 4 * (DRAIN_CYC + 1) + 200;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              ch_valid     [N_CH];
    logic              ch_ready     [N_CH];
    xbar_pkg::op_e     ch_op        [N_CH];
    xbar_pkg::addr_t   ch_addr      [N_CH];
    xbar_pkg::data_t   ch_wdata     [N_CH];
    logic              bank_valid   [N_BANK];
    logic              bank_ready   [N_BANK];
    xbar_pkg::op_e     bank_op      [N_BANK];
    xbar_pkg::addr_t   bank_addr    [N_BANK];
    xbar_pkg::data_t   bank_wdata   [N_BANK];
    logic [N_CH-1:0]   bank_ch_1hot [N_BANK];

    // Stimulus control, written on the falling edge.
    logic              hold_en   [N_BANK];
    logic              hold_val  [N_BANK];
    logic              bank_rand [N_BANK];
    int                xfer_count [N_BANK];
    int                quota    [N_CH];
    int                bank_sel [N_CH];
    int                seen     [N_CH];
    bit                dense;
    bit                idle_chk;
    bit                full_chk;
    bit                rr_chk;

    // Checker state, written on the rising edge.
    int                acc_cnt [N_CH];
    int                rr_last;
    bit                stalled [N_BANK];
    logic [N_CH+48:0]  held    [N_BANK];
    logic [48:0]       sb      [N_CH][N_BANK][$];

    int                errors = 0;
    int                tests_ok = 0;
    int                tests_bad = 0;
    int                cycles = 0;
    int                start;
    int                base;
    logic [31:0]       lfsr = 32'h2e81;

    always #2 clk = ~clk;

    xbar_core #(
        .N_CH         (N_CH),
        .N_BANK       (N_BANK),
        .DEPTH        (DEPTH)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .ch_valid     (ch_valid),
        .ch_ready     (ch_ready),
        .ch_op        (ch_op),
        .ch_addr      (ch_addr),
        .ch_wdata     (ch_wdata),
        .bank_valid   (bank_valid),
        .bank_ready   (bank_ready),
        .bank_op      (bank_op),
        .bank_addr    (bank_addr),
        .bank_wdata   (bank_wdata),
        .bank_ch_1hot (bank_ch_1hot)
    );

    for (genvar b = 0; b < N_BANK; b++) begin : g_bank
        xbar_tb_bank u_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .hold_en    (hold_en[b]),
            .hold_val   (hold_val[b]),
            .rand_bit   (bank_rand[b]),
            .valid      (bank_valid[b]),
            .ready      (bank_ready[b]),
            .xfer_count (xfer_count[b])
        );
    end

    // ##################################################################
    // Helpers
    // ##################################################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int c = 0; c < N_CH; c++) begin
            for (int b = 0; b < N_BANK; b++) begin
                n += sb[c][b].size();
            end
        end
        return n;
    endfunction

    function automatic bit busy();
        bit any;
        any = (pending() != 0);
        for (int c = 0; c < N_CH; c++) begin
            any |= ch_valid[c];
        end
        for (int b = 0; b < N_BANK; b++) begin
            any |= bank_valid[b];
        end
        return any;
    endfunction

    function automatic int first_set(input logic [N_CH-1:0] v);
        int c;
        c = 0;
        for (int i = N_CH - 1; i >= 0; i--) begin
            if (v[i]) begin
                c = i;
            end
        end
        return c;
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
        errors++;
        $display("Fail t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("Error at t=%0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        if (errors == start) begin
            tests_ok++;
            $display("test %-14s ok", name);
        end else begin
            tests_bad++;
            $display("test %-14s failed with %0d errors", name, errors - start);
        end
    endtask

    // One cycle of stimulus. A channel keeps its request until it is taken.
    task automatic step();
        logic [31:0] v;
        @(negedge clk);
        for (int c = 0; c < N_CH; c++) begin
            if (!ch_valid[c] || acc_cnt[c] != seen[c]) begin
                seen[c] = acc_cnt[c];
                take_bits(1, v);
                if (quota[c] > 0 && (dense || v[0])) begin
                    quota[c]--;
                    ch_valid[c] = 1'b1;
                    take_bits(1, v);
                    ch_op[c] = xbar_pkg::op_e'(v[0]);
                    take_bits(16, v);
                    ch_addr[c] = v[15:0];
                    if (bank_sel[c] >= 0) begin
                        ch_addr[c][1:0] = 2'(bank_sel[c]);
                    end
                    take_bits(32, v);
                    ch_wdata[c] = v;
                end else begin
                    ch_valid[c] = 1'b0;
                end
            end
        end
        for (int b = 0; b < N_BANK; b++) begin
            take_bits(1, v);
            bank_rand[b] = v[0];
        end
    endtask

    // Runs until traffic settles, for a bounded number of cycles.
    task automatic drain();
        int n;
        n = 0;
        while (busy() && n < DRAIN_CYC) begin
            step();
            n++;
        end
    endtask

    task automatic wait_xfer(input int b, input int from, input int max_cyc);
        int n;
        n = 0;
        while (xfer_count[b] == from && n < max_cyc) begin
            step();
            n++;
        end
    endtask

    task automatic set_hold(input bit en, input bit val);
        for (int b = 0; b < N_BANK; b++) begin
            hold_en[b]  = en;
            hold_val[b] = val;
        end
    endtask

    task automatic check_idle();
        idle_chk = 1'b1;
        step();
        idle_chk = 1'b0;
    endtask

    // ##################################################################
    // Checking on the rising edge
    // ##################################################################

    always @(posedge clk) begin
        int          c;
        logic [48:0] got;
        if (!rst_n) begin
            for (int b = 0; b < N_BANK; b++) begin
                stalled[b] = 1'b0;
            end
        end else begin
            for (int k = 0; k < N_CH; k++) begin
                if (ch_valid[k] && ch_ready[k]) begin
                    sb[k][ch_addr[k][1:0]].push_back({ch_op[k], ch_addr[k], ch_wdata[k]});
                    acc_cnt[k]++;
                end
                if (idle_chk) begin
                    assert (ch_ready[k]) else report_value($sformatf("ch_ready[%0d]", k), 1, 0);
                end
            end
            if (full_chk) begin
                assert (!ch_ready[0]) else report_value("ch_ready[0]", 0, ch_ready[0]);
            end
            if (idle_chk) begin
                assert (pending() == 0) else report_text("requests never reached a bank");
            end
            for (int b = 0; b < N_BANK; b++) begin
                if (idle_chk) begin
                    assert (!bank_valid[b])
                        else report_value($sformatf("bank_valid[%0d]", b), 0, 1);
                end
                // A stalled bank holds every output.
                if (stalled[b]) begin
                    assert (bank_valid[b])
                        else report_value($sformatf("bank_valid[%0d]", b), 1, 0);
                    assert ({bank_ch_1hot[b], bank_op[b], bank_addr[b], bank_wdata[b]} == held[b])
                        else report_value($sformatf("bank %0d held outputs", b), held[b],
                            {bank_ch_1hot[b], bank_op[b], bank_addr[b], bank_wdata[b]});
                end
                if (bank_valid[b] && bank_ready[b]) begin
                    assert (bank_addr[b][1:0] == 2'(b))
                        else report_value($sformatf("bank_addr[%0d][1:0]", b), b,
                            bank_addr[b][1:0]);
                    assert ($onehot(bank_ch_1hot[b]))
                        else report_text($sformatf("bank %0d channel id is not one-hot", b));
                    c = first_set(bank_ch_1hot[b]);
                    assert (sb[c][b].size() != 0)
                        else report_text($sformatf("bank %0d sent a request never pushed", b));
                    if (sb[c][b].size() != 0) begin
                        got = {bank_op[b], bank_addr[b], bank_wdata[b]};
                        assert (got == sb[c][b][0])
                            else report_value($sformatf("bank %0d op/addr/wdata", b),
                                sb[c][b][0], got);
                        void'(sb[c][b].pop_front());
                    end
                    if (rr_chk && b == 1) begin
                        if (rr_last >= 0) begin
                            assert (c == (rr_last + 1) % N_CH)
                                else report_value("bank_ch_1hot[1]",
                                    1 << ((rr_last + 1) % N_CH), bank_ch_1hot[1]);
                        end
                        rr_last = c;
                    end
                end
                stalled[b] = bank_valid[b] && !bank_ready[b];
                held[b]    = {bank_ch_1hot[b], bank_op[b], bank_addr[b], bank_wdata[b]};
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ##################################################################
    // Test sequence
    // ##################################################################

    initial begin
        rst_n = 1'b0;
        dense = 1'b0;
        idle_chk = 1'b0;
        full_chk = 1'b0;
        rr_chk = 1'b0;
        rr_last = -1;
        set_hold(1'b1, 1'b1);
        for (int b = 0; b < N_BANK; b++) begin
            bank_rand[b] = 1'b0;
        end
        for (int c = 0; c < N_CH; c++) begin
            ch_valid[c] = 1'b0;
            ch_op[c]    = xbar_pkg::OP_READ;
            ch_addr[c]  = '0;
            ch_wdata[c] = '0;
            quota[c]    = 0;
            bank_sel[c] = -1;
            seen[c]     = 0;
            acc_cnt[c]  = 0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        start = errors;
        check_idle();
        end_test("reset state");

        // Random traffic on all channels and banks.
        start = errors;
        set_hold(1'b0, 1'b1);
        for (int c = 0; c < N_CH; c++) begin
            quota[c] = 1 << 20;
        end
        repeat (RAND_CYC) step();
        for (int c = 0; c < N_CH; c++) begin
            quota[c] = 0;
        end
        set_hold(1'b1, 1'b1);
        drain();
        check_idle();
        end_test("random routing");

        // Channel 0 fills up behind a stalled bank 0.
        start = errors;
        dense = 1'b1;
        hold_val[0] = 1'b0;
        bank_sel[0] = 0;
        quota[0] = DEPTH + 4;
        base = acc_cnt[0];
        while (acc_cnt[0] - base < DEPTH) step();
        full_chk = 1'b1;
        repeat (HOLD_CYC) step();
        full_chk = 1'b0;
        quota[0] = 0;
        hold_val[0] = 1'b1;
        drain();
        check_idle();
        end_test("full buffer");

        start = errors;
        hold_val[2] = 1'b0;
        bank_sel[1] = 2;
        quota[1] = 1;
        do step(); while (ch_valid[1]);
        base = xfer_count[3];
        bank_sel[1] = 3;
        quota[1] = 1;
        do step(); while (ch_valid[1]);
        // Bank 2 is still stalled here.
        wait_xfer(3, base, OOO_CYC);
        assert (xfer_count[3] != base)
            else report_text("bank 3 request waited behind stalled bank 2");
        hold_val[2] = 1'b1;
        drain();
        check_idle();
        end_test("bank bypass");

        start = errors;
        rr_last = -1;
        rr_chk = 1'b1;
        for (int c = 0; c < N_CH; c++) begin
            bank_sel[c] = 1;
            quota[c] = RR_PER_CH;
        end
        drain();
        rr_chk = 1'b0;
        check_idle();
        end_test("round robin");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/xbar_pkg.sv
verilog/xbar_ptr_gen.sv
verilog/xbar_buffer.sv
verilog/xbar_matrix.sv
verilog/xbar_core.sv
testbench/xbar_tb_bank.sv
testbench/xbar_tb.sv
